// ==== flist.f ====
src/line_pkg.sv
src/port_pkg.sv
src/line_xfer_if.sv
src/line_arbiter.sv
src/cacheline_adapter.sv
src/mem_subsys.sv
sim/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --assert \
    --top-module tb_mem_subsys \
    -f flist.f \
    -o tb_mem_subsys

if ! ./obj_dir/tb_mem_subsys > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== sim/stim_input.txt ====
// columns: op  address  seed  ready_alt   (all hex)
// op 1 icache read, 2 dcache read, 3 dcache write, 4 paired read (seed column = icache address)
1 00001040 00000000 0
1 0000205c 00000000 0
2 00003000 00000000 0
3 00004020 1234abcd 0
2 00004020 00000000 0
1 00004024 00000000 0
4 00005000 0000606c 0
3 00007fe0 0badf00d 1
2 00007fe0 00000000 1
1 00001040 00000000 1
4 00008044 0000901f 1
3 00003000 5eed5eed 1
1 00003000 00000000 0
4 00007fe4 00004020 1
3 0000a000 00000001 0
2 0000a01f 00000000 1

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int          MAX_REQ  = 32;
    localparam logic [31:0] LCG_SEED = 32'hd3f64530;

    logic                                  clk;
    logic                                  rst;
    logic [port_pkg::ADDR_BITS-1:0]        i_dfp_addr_i;
    logic                                  i_dfp_read_i;
    logic [line_pkg::LINE_BITS-1:0]        i_dfp_rdata_o;
    logic                                  i_dfp_resp_o;
    logic [port_pkg::ADDR_BITS-1:0]        d_dfp_addr_i;
    logic                                  d_dfp_read_i;
    logic                                  d_dfp_write_i;
    logic [line_pkg::LINE_BITS-1:0]        d_dfp_wdata_i;
    logic [line_pkg::LINE_BITS-1:0]        d_dfp_rdata_o;
    logic                                  d_dfp_resp_o;
    logic [port_pkg::ADDR_BITS-1:0]        bmem_addr_o;
    logic                                  bmem_read_o;
    logic                                  bmem_write_o;
    logic [line_pkg::BURST_BITS-1:0]       bmem_wdata_o;
    logic                                  bmem_ready_i;
    logic [line_pkg::BURST_BITS-1:0]       bmem_rdata_i;
    logic                                  bmem_rvalid_i;

    logic [31:0]  stim [0:MAX_REQ*4-1];     // op, addr, seed, ready flag per request
    int           errors;
    int           checks;
    int           n_req;
    int           cycles;
    int           cycle_limit = 1000;       // replaced once the stimulus is loaded

    logic [63:0]  mem_beats [logic [31:0]]; // model storage by beat address
    logic [255:0] written [logic [31:0]];   // lines expected back after writes
    logic [31:0]  read_addrs [$];           // burst reads seen for the current request
    logic [255:0] exp_wline;
    logic [31:0]  exp_waddr;
    int           wr_beat;
    int           wr_count;
    logic         ready_alt;

    mem_subsys dut_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // write line built from eight generator words
    function automatic logic [255:0] seeded_line(input logic [31:0] seed);
        logic [31:0]  s;
        logic [255:0] line;
        int           w;
        s = LCG_SEED ^ seed;
        for (w = 0; w < 8; w++) begin
            s = lcg_next(s);
            line[w*32 +: 32] = s;
        end
        return line;
    endfunction

    // contents of a beat nobody has written yet
    function automatic logic [63:0] default_beat(input logic [31:0] line_addr, input int k);
        return {line_addr + 32'(k), ~line_addr ^ (32'(k) << 28)};
    endfunction

    function automatic logic [31:0] align_line(input logic [31:0] addr);
        return {addr[31:5], 5'b0};
    endfunction

    function automatic logic [255:0] expected_line(input logic [31:0] line_addr);
        logic [255:0] line;
        int           k;
        if (written.exists(line_addr)) begin
            return written[line_addr];
        end
        for (k = 0; k < 4; k++) begin
            line[k*64 +: 64] = default_beat(line_addr, k);    // beat 0 lowest
        end
        return line;
    endfunction

    task automatic compare_value(input string name, input logic [255:0] exp,
                                 input logic [255:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // runs one request from the list with op 1 to 4
    task automatic run_request(input logic [3:0] op, input logic [31:0] addr,
                               input logic [31:0] seed, input logic alt);
        logic        use_i;
        logic        use_d;
        logic        i_done;
        logic        d_done;
        logic [31:0] i_addr;
        logic [31:0] exp_reads [$];
        int          k;
        if (op == 4'd0 || op > 4'd4) begin
            report_fault($sformatf("unknown op %0h in the stimulus file", op));
            return;
        end
        i_addr = (op == 4'd4) ? seed : addr;  // paired op carries the icache address here
        use_i = (op == 4'd1) || (op == 4'd4);
        use_d = (op != 4'd1);
        read_addrs.delete();
        wr_count  = 0;
        wr_beat   = 0;
        exp_waddr = align_line(addr);
        exp_wline = seeded_line(seed);
        ready_alt = alt;
        i_dfp_addr_i  = i_addr;
        i_dfp_read_i  = use_i;
        d_dfp_addr_i  = addr;
        d_dfp_read_i  = use_d && (op != 4'd3);
        d_dfp_write_i = (op == 4'd3);
        d_dfp_wdata_i = (op == 4'd3) ? exp_wline : '0;
        i_done = !use_i;
        d_done = !use_d;
        while (!(i_done && d_done)) begin
            @(posedge clk);
            if (d_dfp_resp_o && !d_done) begin
                d_done = 1'b1;
                if (op != 4'd3) begin
                    compare_value("d_dfp_rdata_o", expected_line(align_line(addr)),
                                  d_dfp_rdata_o);
                end
            end
            if (i_dfp_resp_o && !i_done) begin
                if (op == 4'd4 && !d_done) begin
                    report_fault("icache was answered before dcache on a paired request");
                end
                i_done = 1'b1;
                compare_value("i_dfp_rdata_o", expected_line(align_line(i_addr)),
                              i_dfp_rdata_o);
            end
            #1;
            if (i_done) i_dfp_read_i = 1'b0;
            if (d_done) begin
                d_dfp_read_i  = 1'b0;
                d_dfp_write_i = 1'b0;
            end
        end
        if (op == 4'd3) begin
            written[align_line(addr)] = exp_wline;
            if (wr_count != 4) begin
                report_fault($sformatf("line write carried %0d beats instead of 4", wr_count));
            end
        end else if (wr_count != 0) begin
            report_fault("a read request caused burst writes");
        end
        if (op == 4'd4 || op == 4'd2) exp_reads.push_back(align_line(addr));   // dcache first
        if (use_i) exp_reads.push_back(align_line(i_addr));
        if (read_addrs.size() != exp_reads.size()) begin
            report_fault($sformatf("saw %0d burst reads, wanted %0d",
                                   read_addrs.size(), exp_reads.size()));
        end else begin
            for (k = 0; k < exp_reads.size(); k++) begin
                compare_value("bmem_addr_o", 256'(exp_reads[k]), 256'(read_addrs[k]));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a request never finished", cycles);
        $display("checks: %0d  errors: %0d", checks, errors + 1);
        $display("Test FAILED");
        $finish;
    end

    // burst memory model and response monitor
    initial begin : memory_model
        logic        alt_now;
        logic        phase;
        logic        rd_busy;
        int          rd_wait;
        int          rd_beat;
        logic [31:0] rd_addr;
        logic [31:0] key;
        alt_now = 1'b0;
        phase   = 1'b0;
        rd_busy = 1'b0;
        rd_wait = 0;
        rd_beat = 0;
        rd_addr = '0;
        bmem_ready_i  = 1'b1;
        bmem_rvalid_i = 1'b0;
        bmem_rdata_i  = '0;
        forever begin
            @(posedge clk);
            alt_now = ready_alt;
            if (!rst) begin
                if (bmem_read_o && bmem_ready_i) begin
                    if (rd_busy) report_fault("burst read issued while another was open");
                    read_addrs.push_back(bmem_addr_o);
                    rd_busy = 1'b1;
                    rd_wait = 1;        // first beat two cycles later
                    rd_beat = 0;
                    rd_addr = bmem_addr_o;
                end
                if (bmem_write_o && bmem_ready_i) begin
                    compare_value("bmem_addr_o", 256'(exp_waddr), 256'(bmem_addr_o));
                    compare_value("bmem_wdata_o", 256'(exp_wline[wr_beat*64 +: 64]),
                                  256'(bmem_wdata_o));
                    mem_beats[bmem_addr_o + 32'(wr_beat * 8)] = bmem_wdata_o;
                    wr_beat = (wr_beat + 1) % 4;
                    wr_count++;
                end
                if (i_dfp_resp_o && !i_dfp_read_i) begin
                    report_fault("icache response with no icache request outstanding");
                end
                if (d_dfp_resp_o && !(d_dfp_read_i || d_dfp_write_i)) begin
                    report_fault("dcache response with no dcache request outstanding");
                end
            end
            #1;
            phase = !phase;
            bmem_ready_i  = alt_now ? phase : 1'b1;
            bmem_rvalid_i = 1'b0;
            if (rd_busy) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else if (!alt_now || phase) begin   // gaps between beats when alternating
                    key = rd_addr + 32'(rd_beat * 8);
                    if (mem_beats.exists(key)) begin
                        bmem_rdata_i = mem_beats[key];
                    end else begin
                        bmem_rdata_i = default_beat(rd_addr, rd_beat);
                    end
                    bmem_rvalid_i = 1'b1;
                    rd_beat++;
                    rd_busy = (rd_beat < 4);
                end
            end
        end
    end

    initial begin : run_tests
        int         r;
        logic [3:0] op;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        i_dfp_addr_i  = '0;
        i_dfp_read_i  = 1'b0;
        d_dfp_addr_i  = '0;
        d_dfp_read_i  = 1'b0;
        d_dfp_write_i = 1'b0;
        d_dfp_wdata_i = '0;
        ready_alt = 1'b0;
        wr_beat   = 0;
        wr_count  = 0;
        exp_wline = '0;
        exp_waddr = '0;
        for (r = 0; r < MAX_REQ * 4; r++) begin
            stim[r] = 32'hf;    // op f marks the end of the list
        end
        $readmemh("sim/stim_input.txt", stim);
        n_req = 0;
        while (n_req < MAX_REQ && stim[n_req * 4][3:0] != 4'hf) n_req++;
        cycle_limit = 200 * n_req + 100;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        // nothing moves before the first request
        repeat (3) begin
            @(posedge clk);
            compare_value("bmem_read_o", '0, 256'(bmem_read_o));
            compare_value("bmem_write_o", '0, 256'(bmem_write_o));
            compare_value("i_dfp_resp_o", '0, 256'(i_dfp_resp_o));
            compare_value("d_dfp_resp_o", '0, 256'(d_dfp_resp_o));
        end
        #1;
        if (n_req == 0) report_fault("the stimulus file held no requests");
        for (r = 0; r < n_req; r++) begin
            op = stim[r * 4][3:0];
            run_request(op, stim[r * 4 + 1], stim[r * 4 + 2], stim[r * 4 + 3][0]);
            repeat (2) @(posedge clk);
            #1;
        end
        $display("requests: %0d  checks: %0d  errors: %0d", n_req, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== src/cacheline_adapter.sv ====
`timescale 1ns/1ps

module cacheline_adapter (
    input  logic                              clk,
    input  logic                              rst,

    line_xfer_if.adapt                        xfer,

    // burst memory
    output logic [port_pkg::ADDR_BITS-1:0]    bmem_addr_o,
    output logic                              bmem_read_o,
    output logic                              bmem_write_o,
    output logic [line_pkg::BURST_BITS-1:0]   bmem_wdata_o,
    input  logic                              bmem_ready_i,
    input  logic [line_pkg::BURST_BITS-1:0]   bmem_rdata_i,
    input  logic                              bmem_rvalid_i
);

    enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,       // waiting for ready to send the read
        ST_COLLECT,     // gathering read beats
        ST_SEND,        // pushing write beats
        ST_FINISH       // done pulse
    } state_q, state_d;

    logic [line_pkg::BEAT_IDX_BITS-1:0] beat_q;
    logic                               last_beat;
    logic                               beat_adv;
    logic [port_pkg::ADDR_BITS-1:0]     addr_q;
    line_pkg::line_u                    line_q;     // shared read and write buffer

    assign last_beat = (beat_q == line_pkg::BEAT_IDX_BITS'(line_pkg::BURSTS_PER_LINE - 1));

    // a beat moves on rvalid when reading, on ready when writing
    assign beat_adv = ((state_q == ST_COLLECT) && bmem_rvalid_i) ||
                      ((state_q == ST_SEND) && bmem_ready_i);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (xfer.read) begin
                    state_d = ST_ISSUE;
                end else if (xfer.write) begin
                    state_d = ST_SEND;
                end
            end
            ST_ISSUE: begin
                if (bmem_ready_i) begin
                    state_d = ST_COLLECT;
                end
            end
            ST_COLLECT, ST_SEND: begin
                if (beat_adv && last_beat) begin
                    state_d = ST_FINISH;
                end
            end
            ST_FINISH: state_d = ST_IDLE;   // arbiter drops the request here
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                beat_q <= '0;
            end else if (beat_adv) begin
                beat_q <= beat_q + 1'b1;    // wraps to 0 after beat 3
            end
        end
    end

    // address and line buffer
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            addr_q <= xfer.addr;
            if (xfer.write) begin
                line_q <= xfer.wline;
            end
        end else if ((state_q == ST_COLLECT) && bmem_rvalid_i) begin
            line_q.beat[beat_q] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o  = addr_q;       // held for every beat
    assign bmem_read_o  = (state_q == ST_ISSUE) && bmem_ready_i;
    assign bmem_write_o = (state_q == ST_SEND);
    assign bmem_wdata_o = line_q.beat[beat_q];

    assign xfer.rline = line_q;
    assign xfer.done  = (state_q == ST_FINISH);

    // the granted request stays up and steady until done
    req_held_a: assert property (@(posedge clk) disable iff (rst)
        (state_q != ST_IDLE) |-> ((xfer.read || xfer.write) && (xfer.addr == addr_q)))
        else $error("line request dropped or moved before done");

    // memory must only return data for a read we issued
    rvalid_idle_a: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (state_q != ST_IDLE))
        else $error("read beat arrived with no read outstanding");

endmodule

// ==== src/line_arbiter.sv ====
`timescale 1ns/1ps

module line_arbiter (
    input  logic                              clk,
    input  logic                              rst,

    // read-only icache side
    input  logic [port_pkg::ADDR_BITS-1:0]    i_dfp_addr_i,
    input  logic                              i_dfp_read_i,
    output logic [line_pkg::LINE_BITS-1:0]    i_dfp_rdata_o,
    output logic                              i_dfp_resp_o,

    // dcache side
    input  logic [port_pkg::ADDR_BITS-1:0]    d_dfp_addr_i,
    input  logic                              d_dfp_read_i,
    input  logic                              d_dfp_write_i,
    input  logic [line_pkg::LINE_BITS-1:0]    d_dfp_wdata_i,
    output logic [line_pkg::LINE_BITS-1:0]    d_dfp_rdata_o,
    output logic                              d_dfp_resp_o,

    line_xfer_if.arb                          xfer
);

    logic busy_q;       // a transfer is granted
    logic owner_q;      // who holds the grant
    logic i_req;
    logic d_req;
    logic sel_i;
    logic sel_d;
    logic [port_pkg::ADDR_BITS-1:0] owner_addr;

    assign i_req = i_dfp_read_i;
    assign d_req = d_dfp_read_i || d_dfp_write_i;

    // dcache wins when both ask from idle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= port_pkg::REQ_ICACHE;
        end else if (busy_q) begin
            if (xfer.done) begin
                busy_q <= 1'b0;     // requester drops its level next cycle
            end
        end else if (d_req) begin
            busy_q  <= 1'b1;
            owner_q <= port_pkg::REQ_DCACHE;
        end else if (i_req) begin
            busy_q  <= 1'b1;
            owner_q <= port_pkg::REQ_ICACHE;
        end
    end

    assign sel_i = busy_q && (owner_q == port_pkg::REQ_ICACHE);
    assign sel_d = busy_q && (owner_q == port_pkg::REQ_DCACHE);

    // request toward the adapter
    assign xfer.read  = (sel_i && i_dfp_read_i) || (sel_d && d_dfp_read_i);
    assign xfer.write = sel_d && d_dfp_write_i;   // icache never writes

    assign owner_addr = (owner_q == port_pkg::REQ_DCACHE) ? d_dfp_addr_i : i_dfp_addr_i;

    // strip the byte offset inside the line
    assign xfer.addr = {owner_addr[port_pkg::ADDR_BITS-1:line_pkg::LINE_OFFSET_BITS],
                        {line_pkg::LINE_OFFSET_BITS{1'b0}}};

    assign xfer.wline.flat = d_dfp_wdata_i;

    // response and data only to the owner
    assign i_dfp_resp_o  = sel_i && xfer.done;
    assign d_dfp_resp_o  = sel_d && xfer.done;
    assign i_dfp_rdata_o = sel_i ? xfer.rline.flat : '0;
    assign d_dfp_rdata_o = sel_d ? xfer.rline.flat : '0;

    // a cache is answered only while its request is up
    resp_owner_a: assert property (@(posedge clk) disable iff (rst)
        !(i_dfp_resp_o && !i_req) && !(d_dfp_resp_o && !d_req))
        else $error("a cache was answered with no request up");

    // dcache must not ask for read and write at once
    rw_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(xfer.read && xfer.write))
        else $error("line transfer is both read and write");

endmodule

// ==== src/line_pkg.sv ====
package line_pkg;

    // cacheline geometry
    localparam int LINE_BITS        = 256;
    localparam int LINE_OFFSET_BITS = 5;    // 32 bytes per line

    // burst memory geometry
    localparam int BURST_BITS       = 64;
    localparam int BURSTS_PER_LINE  = 4;
    localparam int BEAT_IDX_BITS    = 2;

    // one line seen either flat or as memory beats
    // beat 0 sits in the low 64 bits
    typedef union packed {
        logic [LINE_BITS-1:0]                       flat;
        logic [BURSTS_PER_LINE-1:0][BURST_BITS-1:0] beat;
    } line_u;

endpackage

// ==== src/line_xfer_if.sv ====
`timescale 1ns/1ps

// one granted line transfer from arbiter to adapter
interface line_xfer_if;

    logic [port_pkg::ADDR_BITS-1:0] addr;   // line aligned
    logic                           read;
    logic                           write;
    line_pkg::line_u                wline;  // line to write back
    line_pkg::line_u                rline;  // line filled from memory
    logic                           done;   // one cycle pulse

    modport arb (
        output addr,
        output read,
        output write,
        output wline,
        input  rline,
        input  done
    );

    modport adapt (
        input  addr,
        input  read,
        input  write,
        input  wline,
        output rline,
        output done
    );

endinterface

// ==== src/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys (
    input  logic                              clk,
    input  logic                              rst,

    // icache line port
    input  logic [port_pkg::ADDR_BITS-1:0]    i_dfp_addr_i,
    input  logic                              i_dfp_read_i,
    output logic [line_pkg::LINE_BITS-1:0]    i_dfp_rdata_o,
    output logic                              i_dfp_resp_o,

    // dcache line port
    input  logic [port_pkg::ADDR_BITS-1:0]    d_dfp_addr_i,
    input  logic                              d_dfp_read_i,
    input  logic                              d_dfp_write_i,
    input  logic [line_pkg::LINE_BITS-1:0]    d_dfp_wdata_i,
    output logic [line_pkg::LINE_BITS-1:0]    d_dfp_rdata_o,
    output logic                              d_dfp_resp_o,

    // burst memory port
    output logic [port_pkg::ADDR_BITS-1:0]    bmem_addr_o,
    output logic                              bmem_read_o,
    output logic                              bmem_write_o,
    output logic [line_pkg::BURST_BITS-1:0]   bmem_wdata_o,
    input  logic                              bmem_ready_i,
    input  logic [line_pkg::BURST_BITS-1:0]   bmem_rdata_i,
    input  logic                              bmem_rvalid_i
);

    line_xfer_if xfer_if ();    // granted transfer

    line_arbiter arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .i_dfp_addr_i  (i_dfp_addr_i),
        .i_dfp_read_i  (i_dfp_read_i),
        .i_dfp_rdata_o (i_dfp_rdata_o),
        .i_dfp_resp_o  (i_dfp_resp_o),
        .d_dfp_addr_i  (d_dfp_addr_i),
        .d_dfp_read_i  (d_dfp_read_i),
        .d_dfp_write_i (d_dfp_write_i),
        .d_dfp_wdata_i (d_dfp_wdata_i),
        .d_dfp_rdata_o (d_dfp_rdata_o),
        .d_dfp_resp_o  (d_dfp_resp_o),
        .xfer          (xfer_if.arb)
    );

    // bursts to and from memory
    cacheline_adapter adapter_i (
        .clk           (clk),
        .rst           (rst),
        .xfer          (xfer_if.adapt),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule

// ==== src/port_pkg.sv ====
package port_pkg;

    localparam int ADDR_BITS = 32;  // byte address

    // owner codes for the line arbiter
    localparam logic REQ_ICACHE = 1'b0;
    localparam logic REQ_DCACHE = 1'b1;

endpackage
